// ==== source/rvPkg.sv ====
package rvPkg;

    localparam int XLEN = 32; // data word width

    // instruction cycle steps, one cycle each
    typedef enum logic [2:0] {
        sFetch     = 3'd0,
        sDecode    = 3'd1,
        sExecute   = 3'd2,
        sMemory    = 3'd3,
        sWriteBack = 3'd4,
        sNextPc    = 3'd5,
        sHalt      = 3'd6
    } cpuState_e;

    // RV32I major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5
    } aluOp_e;

endpackage

// ==== source/controlFsm.sv ====
`timescale 1ns/10ps

module controlFsm (
    input  logic           clk,
    input  logic           rst,
    input  rvPkg::opcode_e opcode,
    input  logic           isZero,
    output logic           irLoad,
    output logic           aluEn,
    output logic           memWe,
    output logic           regWe,
    output logic           pcStep,
    output logic           done
);
    import rvPkg::*;

    cpuState_e state;
    cpuState_e nextState;
    logic      writesReg; // instruction has a destination register

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            sFetch:     nextState = sDecode;
            sDecode:    nextState = isZero ? sHalt : sExecute; // all-zero word stops the run
            sExecute:   nextState = sMemory;
            sMemory:    nextState = sWriteBack;
            sWriteBack: nextState = sNextPc;
            sNextPc:    nextState = sFetch;
            sHalt:      nextState = sHalt;
            default:    nextState = sFetch;
        endcase
    end

    // stores only touch memory, branches write nothing
    assign writesReg = (opcode == opR) || (opcode == opImm) || (opcode == opLoad);

    assign irLoad = (state == sFetch);
    assign aluEn  = (state == sExecute);
    assign memWe  = (state == sMemory) && (opcode == opStore);
    assign regWe  = (state == sWriteBack) && writesReg;
    assign pcStep = (state == sNextPc);
    assign done   = (state == sHalt);

endmodule

// ==== source/progCounter.sv ====
`timescale 1ns/10ps

module progCounter #(
    parameter int IMEM_WORDS = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pcStep,
    input  logic                          branchTaken,
    input  logic [rvPkg::XLEN-1:0]        immediate,
    output logic [$clog2(IMEM_WORDS)-1:0] pc
);
    import rvPkg::*;

    localparam int PC_W = $clog2(IMEM_WORDS);

    logic signed [XLEN-1:0] stride;
    logic signed [XLEN-1:0] target;
    logic signed [XLEN-1:0] wrapped;

    always_comb begin
        // byte offset to word offset, sign kept
        stride  = branchTaken ? ($signed(immediate) >>> 2) : XLEN'(1);
        target  = $signed(XLEN'(pc)) + stride;
        wrapped = target % IMEM_WORDS;
        if (wrapped < 0) begin
            wrapped = wrapped + IMEM_WORDS; // backward wrap past word 0
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcStep) begin
            pc <= wrapped[PC_W-1:0];
        end
    end

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder (
    input  logic                   clk,
    input  logic [31:0]            instr,
    input  logic                   irLoad,
    output rvPkg::opcode_e         opcode,
    output logic [4:0]             rd,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output logic [rvPkg::XLEN-1:0] immediate,
    output rvPkg::aluOp_e          aluOp,
    output logic                   useImm,
    output logic                   memToReg,
    output logic                   isBranch,
    output logic                   isBranchNe,
    output logic                   isZero
);
    import rvPkg::*;

    logic [31:0] ir;     // instruction register
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    always_ff @(posedge clk) begin
        if (irLoad) begin
            ir <= instr;
        end
    end

    assign opcode = opcode_e'(ir[6:0]);
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];
    assign isZero = (ir == '0);

    always_comb begin
        case (opcode)
            opImm, opLoad: immediate = {{20{ir[31]}}, ir[31:20]};
            opStore:       immediate = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            opBranch:      immediate = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            default:       immediate = '0;
        endcase
    end

    always_comb begin
        aluOp = aluAdd; // address calc for lw and sw
        if (opcode == opR || opcode == opImm) begin
            case (funct3)
                3'b000:  aluOp = (opcode == opR && funct7[5]) ? aluSub : aluAdd;
                3'b010:  aluOp = aluSlt;
                3'b100:  aluOp = aluXor;
                3'b110:  aluOp = aluOr;
                3'b111:  aluOp = aluAnd;
                default: aluOp = aluAdd;
            endcase
        end else if (opcode == opBranch) begin
            aluOp = aluSub; // compare by difference
        end
    end

    assign useImm     = (opcode == opImm) || (opcode == opLoad) || (opcode == opStore);
    assign memToReg   = (opcode == opLoad);
    assign isBranch   = (opcode == opBranch);
    assign isBranchNe = isBranch && (funct3 == 3'b001);

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   regWe,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  logic [4:0]             rd,
    input  logic [rvPkg::XLEN-1:0] writeData,
    output logic [rvPkg::XLEN-1:0] readData1,
    output logic [rvPkg::XLEN-1:0] readData2,
    output logic [rvPkg::XLEN-1:0] x5Value
);

    logic [rvPkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= writeData;
        end
    end

    assign readData1 = regs[rs1];
    assign readData2 = regs[rs2];
    assign x5Value   = regs[5]; // display tap

endmodule

// ==== source/aluUnit.sv ====
`timescale 1ns/10ps

module aluUnit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   aluEn,
    input  rvPkg::aluOp_e          aluOp,
    input  logic                   useImm,
    input  logic                   isBranch,
    input  logic                   isBranchNe,
    input  logic [rvPkg::XLEN-1:0] opA,
    input  logic [rvPkg::XLEN-1:0] opB,
    input  logic [rvPkg::XLEN-1:0] immediate,
    output logic [rvPkg::XLEN-1:0] result,
    output logic                   branchTaken
);
    import rvPkg::*;

    logic [XLEN-1:0] operandB;
    logic [XLEN-1:0] aluValue;
    logic            isEqual; // zero test on the difference

    assign operandB = useImm ? immediate : opB;

    always_comb begin
        case (aluOp)
            aluAdd:  aluValue = opA + operandB;
            aluSub:  aluValue = opA - operandB;
            aluAnd:  aluValue = opA & operandB;
            aluOr:   aluValue = opA | operandB;
            aluXor:  aluValue = opA ^ operandB;
            aluSlt:  aluValue = ($signed(opA) < $signed(operandB)) ? XLEN'(1) : '0;
            default: aluValue = '0;
        endcase
    end

    assign isEqual = (aluValue == '0);

    always_ff @(posedge clk) begin
        if (aluEn) begin
            result <= aluValue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branchTaken <= 1'b0;
        end else if (aluEn) begin
            branchTaken <= isBranch && (isBranchNe ? !isEqual : isEqual); // beq or bne
        end
    end

endmodule

// ==== source/instrMem.sv ====
`timescale 1ns/10ps

module instrMem #(
    parameter int IMEM_WORDS = 32
) (
    input  logic                          clk,
    input  logic                          progWe,
    input  logic [$clog2(IMEM_WORDS)-1:0] progAddr,
    input  logic [31:0]                   progData,
    input  logic [$clog2(IMEM_WORDS)-1:0] pc,
    output logic [31:0]                   instr
);

    logic [31:0] mem [IMEM_WORDS]; // program survives rst

    // loaded from the testbench while rst is held
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign instr = mem[pc]; // async read

endmodule

// ==== source/dataMem.sv ====
`timescale 1ns/10ps

module dataMem #(
    parameter int DMEM_WORDS = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   memWe,
    input  logic [rvPkg::XLEN-1:0] addr,
    input  logic [rvPkg::XLEN-1:0] storeData,
    output logic [rvPkg::XLEN-1:0] loadData
);
    import rvPkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [XLEN-1:0] wordSel;
    logic [AW-1:0]   wordIdx;

    assign wordSel = (addr >> 2) % DMEM_WORDS; // drop byte offset, fold into depth
    assign wordIdx = wordSel[AW-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (memWe) begin
            mem[wordIdx] <= storeData;
        end
    end

    assign loadData = mem[wordIdx];

endmodule

// ==== source/displayDriver.sv ====
`timescale 1ns/10ps

module displayDriver (
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [rvPkg::XLEN-1:0] x5Value,
    input  logic                   done,
    output logic [6:0]             display1,
    output logic [6:0]             display2,
    output logic [6:0]             display3,
    output logic [6:0]             display4,
    output logic [6:0]             display5
);
    import rvPkg::*;

    // segments as {g,f,e,d,c,b,a}, lit when high
    function automatic logic [6:0] segOf(input logic [XLEN-1:0] digit);
        case (digit)
            0:       segOf = 7'h3F;
            1:       segOf = 7'h06;
            2:       segOf = 7'h5B;
            3:       segOf = 7'h4F;
            4:       segOf = 7'h66;
            5:       segOf = 7'h6D;
            6:       segOf = 7'h7D;
            7:       segOf = 7'h07;
            8:       segOf = 7'h7F;
            9:       segOf = 7'h6F;
            default: segOf = 7'h00;
        endcase
    endfunction

    logic [XLEN-1:0] pcLow;
    logic [XLEN-1:0] x5Low;

    assign pcLow = pc % 100;
    assign x5Low = x5Value % 100; // unsigned view of x5

    assign display1 = segOf(pcLow % 10);
    assign display2 = segOf(pcLow / 10);
    assign display3 = segOf(x5Low % 10);
    assign display4 = segOf(x5Low / 10);
    assign display5 = done ? 7'h71 : 7'h00; // F once halted

endmodule

// ==== source/riscCore.sv ====
`timescale 1ns/10ps

module riscCore #(
    parameter int IMEM_WORDS = 32,
    parameter int DMEM_WORDS = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          progWe,
    input  logic [$clog2(IMEM_WORDS)-1:0] progAddr,
    input  logic [31:0]                   progData,
    output logic [6:0]                    display1,
    output logic [6:0]                    display2,
    output logic [6:0]                    display3,
    output logic [6:0]                    display4,
    output logic [6:0]                    display5,
    output logic                          done
);
    import rvPkg::*;

    logic [$clog2(IMEM_WORDS)-1:0] pc;
    logic [XLEN-1:0] pcWide;
    logic [31:0]     instr;
    opcode_e         opcode;
    aluOp_e          aluOp;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] immediate;
    logic            useImm;
    logic            memToReg;
    logic            isBranch;
    logic            isBranchNe;
    logic            isZero;
    logic            irLoad;
    logic            aluEn;
    logic            memWe;
    logic            regWe;
    logic            pcStep;
    logic            branchTaken;
    logic [XLEN-1:0] readData1;
    logic [XLEN-1:0] readData2;
    logic [XLEN-1:0] x5Value;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] writeData;

    assign writeData = memToReg ? loadData : aluResult; // lw takes memory, rest take ALU
    assign pcWide    = XLEN'(pc);

    controlFsm controlFsm_i (
        .clk(clk), .rst(rst), .opcode(opcode), .isZero(isZero), .irLoad(irLoad),
        .aluEn(aluEn), .memWe(memWe), .regWe(regWe), .pcStep(pcStep), .done(done)
    );

    progCounter #(.IMEM_WORDS(IMEM_WORDS)) progCounter_i (
        .clk(clk), .rst(rst), .pcStep(pcStep), .branchTaken(branchTaken),
        .immediate(immediate), .pc(pc)
    );

    instrMem #(.IMEM_WORDS(IMEM_WORDS)) instrMem_i (
        .clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .instr(instr)
    );

    instrDecoder instrDecoder_i (
        .clk(clk), .instr(instr), .irLoad(irLoad), .opcode(opcode), .rd(rd), .rs1(rs1),
        .rs2(rs2), .immediate(immediate), .aluOp(aluOp), .useImm(useImm),
        .memToReg(memToReg), .isBranch(isBranch), .isBranchNe(isBranchNe), .isZero(isZero)
    );

    regFile regFile_i (
        .clk(clk), .rst(rst), .regWe(regWe), .rs1(rs1), .rs2(rs2), .rd(rd),
        .writeData(writeData), .readData1(readData1), .readData2(readData2),
        .x5Value(x5Value)
    );

    aluUnit aluUnit_i (
        .clk(clk), .rst(rst), .aluEn(aluEn), .aluOp(aluOp), .useImm(useImm),
        .isBranch(isBranch), .isBranchNe(isBranchNe), .opA(readData1), .opB(readData2),
        .immediate(immediate), .result(aluResult), .branchTaken(branchTaken)
    );

    dataMem #(.DMEM_WORDS(DMEM_WORDS)) dataMem_i (
        .clk(clk), .rst(rst), .memWe(memWe), .addr(aluResult), .storeData(readData2),
        .loadData(loadData)
    );

    displayDriver displayDriver_i (
        .pc(pcWide), .x5Value(x5Value), .done(done), .display1(display1),
        .display2(display2), .display3(display3), .display4(display4), .display5(display5)
    );

endmodule

// ==== tests/riscCore_assert.sv ====
`timescale 1ns/10ps

module riscCore_assert (
    input logic                   clk,
    input logic                   rst,
    input rvPkg::cpuState_e       state,
    input logic                   irLoad,
    input logic                   aluEn,
    input logic                   memWe,
    input logic                   regWe,
    input logic                   pcStep,
    input logic [4:0]             rs1,
    input logic [rvPkg::XLEN-1:0] readData1
);
    import rvPkg::*;

    executeThenMemory: assert property (@(posedge clk) disable iff (rst)
        state == sExecute |=> state == sMemory)
        else $error("sExecute was not followed by sMemory");

    haltHolds: assert property (@(posedge clk) disable iff (rst)
        state == sHalt |=> state == sHalt)
        else $error("sHalt left while rst was low");

    x0ReadsZero: assert property (@(posedge clk) disable iff (rst)
        rs1 == 5'd0 |-> readData1 == '0)
        else $error("x0 read back nonzero");

    singleEnable: assert property (@(posedge clk) disable iff (rst)
        $onehot0({irLoad, aluEn, memWe, regWe, pcStep}))
        else $error("more than one enable high in a cycle");

endmodule

bind riscCore riscCore_assert riscCore_assert_i (
    .clk(clk), .rst(rst), .state(controlFsm_i.state), .irLoad(irLoad), .aluEn(aluEn),
    .memWe(memWe), .regWe(regWe), .pcStep(pcStep), .rs1(rs1), .readData1(readData1)
);

// ==== tests/riscCore_tb.sv ====
`timescale 1ns/10ps

module riscCore_tb;

    localparam int IMEM_WORDS   = 32;
    localparam int DMEM_WORDS   = 32;
    localparam int PA_W         = $clog2(IMEM_WORDS);
    localparam int NUM_ROWS     = 5;
    localparam int RESET_CYCLES = 16;

    logic            clk;
    logic            rst;
    logic            progWe;
    logic [PA_W-1:0] progAddr;
    logic [31:0]     progData;
    logic [6:0]      display1;
    logic [6:0]      display2;
    logic [6:0]      display3;
    logic [6:0]      display4;
    logic [6:0]      display5;
    logic            done;

    // one program per row with the halt word last
    logic [31:0] progTable [NUM_ROWS][IMEM_WORDS];
    int          progLen   [NUM_ROWS];
    logic [31:0] expX5     [NUM_ROWS];
    int          expPc     [NUM_ROWS];
    int          expCycles [NUM_ROWS]; // 6N+2 plus loop passes
    int          maxCycles [NUM_ROWS];

    int   errors;
    int   checks;
    int   seed;
    logic tableReady;

    riscCore #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) riscCore_i (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .display1(display1), .display2(display2), .display3(display3),
        .display4(display4), .display5(display5), .done(done)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    // addi and lw share the I format
    function automatic logic [31:0] encodeI(input logic [2:0] f3, input logic [6:0] opc,
                                            input int rd, input int rs1, input int imm);
        logic [11:0] im;
        im = 12'(imm);
        return {im, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] encodeStore(input int rs2, input int rs1, input int off);
        logic [11:0] im;
        im = 12'(off);
        return {im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encodeBranch(input logic [2:0] f3, input int rs1,
                                                 input int rs2, input int off);
        logic [12:0] im;
        im = 13'(off);
        return {im[12], im[10:5], 5'(rs2), 5'(rs1), f3, im[4:1], im[11], 7'b1100011};
    endfunction

    // segments {g,f,e,d,c,b,a} back to a digit or 0xF when unlit
    function automatic logic [31:0] segDigit(input logic [6:0] seg);
        case (seg)
            7'h3F:   return 32'd0;
            7'h06:   return 32'd1;
            7'h5B:   return 32'd2;
            7'h4F:   return 32'd3;
            7'h66:   return 32'd4;
            7'h6D:   return 32'd5;
            7'h7D:   return 32'd6;
            7'h07:   return 32'd7;
            7'h7F:   return 32'd8;
            7'h6F:   return 32'd9;
            default: return 32'hF;
        endcase
    endfunction

    task automatic addWord(input int r, input logic [31:0] word);
        progTable[r][progLen[r]] = word;
        progLen[r]++;
    endtask

    task automatic setExpected(input int r, input logic [31:0] x5, input int pcIdx,
                               input int cyc, input int limit);
        expX5[r]     = x5;
        expPc[r]     = pcIdx;
        expCycles[r] = cyc;
        maxCycles[r] = limit;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic buildTable();
        int a;
        int b;
        int sum;
        int xorV;
        int lt;
        for (int r = 0; r < NUM_ROWS; r++) begin
            progLen[r] = 0;
        end
        a = $random(seed) % 2048; // fits a 12-bit immediate
        b = $random(seed) % 2048;
        addWord(0, encodeI(3'b000, 7'b0010011, 1, 0, a));
        addWord(0, encodeI(3'b000, 7'b0010011, 2, 0, b));
        addWord(0, encodeR(7'h00, 3'b000, 3, 1, 2));  // add
        addWord(0, encodeR(7'h20, 3'b000, 4, 3, 1));  // sub gives b back
        addWord(0, encodeR(7'h00, 3'b111, 6, 1, 2));  // and
        addWord(0, encodeR(7'h00, 3'b110, 7, 1, 2));  // or
        addWord(0, encodeR(7'h00, 3'b100, 8, 6, 7));  // xor
        addWord(0, encodeR(7'h00, 3'b010, 9, 1, 2));  // slt
        addWord(0, encodeR(7'h00, 3'b000, 10, 4, 8));
        addWord(0, encodeR(7'h00, 3'b000, 10, 10, 9));
        addWord(0, encodeR(7'h00, 3'b000, 5, 10, 3));
        sum  = a + b;
        xorV = (a & b) ^ (a | b);
        lt   = (a < b) ? 1 : 0;
        setExpected(0, 32'((sum - a) + xorV + lt + sum), 11, 68, 100);
        // store then overwrite the source and load back
        addWord(1, encodeI(3'b000, 7'b0010011, 1, 0, 291));
        addWord(1, encodeI(3'b000, 7'b0010011, 2, 0, 8));
        addWord(1, encodeStore(1, 2, 4));
        addWord(1, encodeI(3'b000, 7'b0010011, 1, 1, 5));
        addWord(1, encodeI(3'b010, 7'b0000011, 5, 2, 4));
        setExpected(1, 32'd291, 5, 32, 50);
        // countdown of 7 then a taken beq over addi
        addWord(2, encodeI(3'b000, 7'b0010011, 1, 0, 7));
        addWord(2, encodeI(3'b000, 7'b0010011, 5, 0, 0));
        addWord(2, encodeI(3'b000, 7'b0010011, 5, 5, 1));
        addWord(2, encodeI(3'b000, 7'b0010011, 1, 1, -1));
        addWord(2, encodeBranch(3'b001, 1, 0, -8));
        addWord(2, encodeBranch(3'b000, 1, 0, 8));
        addWord(2, encodeI(3'b000, 7'b0010011, 5, 5, 40));
        setExpected(2, 32'd7, 7, 146, 200);
        addWord(3, encodeI(3'b000, 7'b0010011, 5, 0, 3));
        addWord(3, encodeI(3'b000, 7'b0010011, 5, 5, 4));
        addWord(3, encodeI(3'b000, 7'b0010011, 6, 5, 1));
        addWord(3, encodeI(3'b000, 7'b0010011, 5, 5, 10));
        setExpected(3, 32'd17, 4, 26, 40);
        // writes to x0 must vanish
        addWord(4, encodeI(3'b000, 7'b0010011, 5, 0, 33));
        addWord(4, encodeI(3'b000, 7'b0010011, 0, 0, 55));
        addWord(4, encodeI(3'b000, 7'b0010011, 1, 0, 9));
        addWord(4, encodeR(7'h00, 3'b000, 0, 1, 1));
        addWord(4, encodeR(7'h00, 3'b000, 5, 0, 0));
        setExpected(4, 32'd0, 5, 32, 50);
        for (int r = 0; r < NUM_ROWS; r++) begin
            addWord(r, 32'h0000_0000); // halt
        end
    endtask

    task automatic runRow(input int r);
        int          cycles;
        logic [31:0] x5Low;
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            progWe   = (c < progLen[r]);
            progAddr = PA_W'(c);
            progData = (c < progLen[r]) ? progTable[r][c] : 32'h0;
            @(posedge clk);
            #1;
        end
        progWe = 1'b0;
        checkValue("display1 after reset", segDigit(display1), 32'd0);
        checkValue("display2 after reset", segDigit(display2), 32'd0);
        checkValue("display3 after reset", segDigit(display3), 32'd0);
        checkValue("display4 after reset", segDigit(display4), 32'd0);
        checkValue("display5 after reset", 32'(display5), 32'h00);
        checkValue("done after reset", 32'(done), 32'd0);
        rst    = 1'b0;
        cycles = 0;
        while (!done && cycles < maxCycles[r]) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            errors++;
            $display("row %0d: done did not rise within %0d cycles", r, maxCycles[r]);
        end else begin
            x5Low = expX5[r] % 100;
            checkValue("cycles to done", 32'(cycles), 32'(expCycles[r]));
            checkValue("display1 (pc units)", segDigit(display1), 32'(expPc[r] % 10));
            checkValue("display2 (pc tens)", segDigit(display2), 32'(expPc[r] / 10));
            checkValue("display3 (x5 units)", segDigit(display3), x5Low % 10);
            checkValue("display4 (x5 tens)", segDigit(display4), x5Low / 10);
            checkValue("display5 (halt mark)", 32'(display5), 32'h71);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        errors     = 0;
        checks     = 0;
        seed       = 24288;
        tableReady = 1'b0;
        buildTable();
        tableReady = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // backstop sized from every row's cycle limit plus its reset
    initial begin
        int limit;
        limit = 0;
        wait (tableReady);
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += RESET_CYCLES + maxCycles[r] + 4;
        end
        #(limit * 10);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== riscCore.f ====
source/rvPkg.sv
source/controlFsm.sv
source/progCounter.sv
source/instrDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/instrMem.sv
source/dataMem.sv
source/displayDriver.sv
source/riscCore.sv
tests/riscCore_assert.sv
tests/riscCore_tb.sv

// ==== Makefile ====
# Verilator build and run for the riscCore testbench

VERILATOR ?= verilator
TOP       ?= riscCore_tb
FILELIST  ?= riscCore.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx 'STATUS: PASS' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
